//--- include/av_cfg.svh
`ifndef AV_CFG_SVH
`define AV_CFG_SVH

// Horizontal line layout in pixel clocks
// Order on the wire is sync, back porch, active, front porch
`define H_ACTIVE 480
`define H_SYNC 1
`define H_BACK 40
`define H_FRONT 1

// Vertical frame layout in lines
`define V_ACTIVE 272
`define V_SYNC 1
`define V_BACK 10
`define V_FRONT 1

// Full period lengths
`define H_TOTAL (`H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT)
`define V_TOTAL (`V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT)

// Width of the x and y coordinates handed to the pixel logic
// 9 bits cover both 480 and 272
`define COORD_BITS 9

// Audio sample and PWM resolution
`define AUDIO_BITS 8

// First visible line of the audio level bar
`define BAR_TOP 256

`endif

//--- hdl/video_pkg.sv
`include "av_cfg.svh"

package video_pkg;

	// One 24-bit panel pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Panel position and control, decoded from the timing counters
	typedef struct packed {
		logic [`COORD_BITS-1:0] x;
		logic [`COORD_BITS-1:0] y;
		logic de;
		logic hsync;
		logic vsync;
		logic disp;
	} tft_pos_t;

	// Word that goes out to the panel pins
	typedef struct packed {
		rgb_t rgb;
		logic de;
		logic hsync;
		logic vsync;
		logic disp;
	} tft_out_t;

	// Fixed colours of the border and bar
	localparam rgb_t RGB_BLACK = 24'h000000;
	localparam rgb_t RGB_RED = 24'hff0000;
	localparam rgb_t RGB_GREEN = 24'h00ff00;
	localparam rgb_t RGB_BLUE = 24'h0000ff;
	localparam rgb_t RGB_YELLOW = 24'hffff00;
	localparam rgb_t RGB_WHITE = 24'hffffff;

	// Blank panel, syncs inactive (high)
	localparam tft_out_t TFT_IDLE = '{
		rgb: RGB_BLACK,
		de: 1'b0,
		hsync: 1'b1,
		vsync: 1'b1,
		disp: 1'b0
	};

endpackage

//--- hdl/audio_pkg.sv
`include "av_cfg.svh"

package audio_pkg;

	// Unsigned audio sample, also used as PWM duty
	typedef logic [`AUDIO_BITS-1:0] sample_t;

	// Silence, zero duty
	localparam sample_t SAMPLE_ZERO = '0;

endpackage

//--- hdl/tft_timing.sv
`timescale 1ns/1ps
`include "av_cfg.svh"

module tft_timing (
	input logic clk,
	input logic rst_n,
	input logic en,
	output video_pkg::tft_pos_t pos
);

	localparam int HW = $clog2(`H_TOTAL);
	localparam int VW = $clog2(`V_TOTAL);
	localparam int CW = `COORD_BITS;

	// Region boundaries, counted from the start of sync
	localparam int H_ACT_START = `H_SYNC + `H_BACK;
	localparam int H_ACT_END = H_ACT_START + `H_ACTIVE;
	localparam int V_ACT_START = `V_SYNC + `V_BACK;
	localparam int V_ACT_END = V_ACT_START + `V_ACTIVE;

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic h_last;
	logic v_last;
	logic h_act;
	logic v_act;
	logic h_sync_reg;
	logic v_sync_reg;
	logic disp_q;

	assign h_last = hcnt == HW'(`H_TOTAL - 1);
	assign v_last = vcnt == VW'(`V_TOTAL - 1);

	// Pixel and line counters
	// Held at zero while the panel is off so a restart begins at line 0, pixel 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (!en) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			if (h_last)
				hcnt <= '0;
			else
				hcnt <= hcnt + 1'b1;

			// One line step per horizontal wrap
			if (h_last) begin
				if (v_last)
					vcnt <= '0;
				else
					vcnt <= vcnt + 1'b1;
			end
		end
	end

	// Panel display enable follows en one clock later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			disp_q <= 1'b0;
		else
			disp_q <= en;
	end

	// Region decode, gated by en so a blanked panel shows no sync or data
	always_comb begin
		h_sync_reg = en && (hcnt < HW'(`H_SYNC));
		v_sync_reg = en && (vcnt < VW'(`V_SYNC));
		h_act = en && (hcnt >= HW'(H_ACT_START)) && (hcnt < HW'(H_ACT_END));
		v_act = en && (vcnt >= VW'(V_ACT_START)) && (vcnt < VW'(V_ACT_END));
	end

	always_comb begin
		pos.x = '0;
		pos.y = '0;
		// Offsets into the active area, zero outside it
		if (h_act)
			pos.x = CW'(hcnt - HW'(H_ACT_START));
		if (v_act)
			pos.y = CW'(vcnt - VW'(V_ACT_START));

		pos.de = h_act && v_act;
		// Syncs are active low
		pos.hsync = !h_sync_reg;
		pos.vsync = !v_sync_reg;
		pos.disp = disp_q;
	end

endmodule

//--- hdl/apu_pwm.sv
`timescale 1ns/1ps
`include "av_cfg.svh"

module apu_pwm #(
	parameter int N = `AUDIO_BITS
) (
	input logic clk,
	input logic rst_n,
	input logic en,
	input audio_pkg::sample_t cmp,
	output logic q,
	output audio_pkg::sample_t duty
);

	localparam int AW = `AUDIO_BITS;

	logic [N-1:0] cnt;
	logic [N-1:0] thresh;
	logic wrap;

	// Scale the duty to the counter width
	// A wider counter gets extra low bits, a narrower one drops them
	generate
		if (N >= AW) begin : g_wide
			assign thresh = N'(duty) << (N - AW);
		end else begin : g_narrow
			assign thresh = N'(duty >> (AW - N));
		end
	endgenerate

	// Last count of the period
	assign wrap = &cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			q <= 1'b0;
			duty <= audio_pkg::SAMPLE_ZERO;
		end else if (en) begin
			cnt <= cnt + 1'b1;
			// High for the first duty steps of each period
			q <= cnt < thresh;

			// New sample takes effect only at the period boundary
			// so a running pulse is never cut short
			if (wrap)
				duty <= cmp;
		end
	end

endmodule

//--- hdl/pixel_compose.sv
`timescale 1ns/1ps
`include "av_cfg.svh"

module pixel_compose (
	input logic clk,
	input logic rst_n,
	input video_pkg::tft_pos_t pos,
	input audio_pkg::sample_t level,
	output video_pkg::tft_out_t tft
);

	localparam int CW = `COORD_BITS;

	video_pkg::rgb_t pattern;
	video_pkg::rgb_t colour;
	video_pkg::tft_out_t tft_d;
	logic [CW-1:0] level_x;
	logic in_bar;

	// Zero-extended level, compared against x
	assign level_x = CW'(level);

	assign in_bar = (pos.y >= CW'(`BAR_TOP)) && (pos.x < level_x);

	// Test pattern, two halves split on the top bit of x
	always_comb begin
		pattern.g = pos.y[7:0];
		if (pos.x[CW-1]) begin
			pattern.r = 8'h00;
			pattern.b = pos.x[7:0];
		end else begin
			pattern.r = pos.x[7:0];
			pattern.b = 8'h00;
		end
	end

	// Colour priority: blanking, borders, level bar, pattern
	always_comb begin
		if (!pos.de)
			colour = video_pkg::RGB_BLACK;
		else if (pos.x == '0)
			colour = video_pkg::RGB_RED;
		else if (pos.x == CW'(`H_ACTIVE - 1))
			colour = video_pkg::RGB_GREEN;
		else if (pos.y == '0)
			colour = video_pkg::RGB_BLUE;
		else if (pos.y == CW'(`V_ACTIVE - 1))
			colour = video_pkg::RGB_YELLOW;
		else if (in_bar)
			colour = video_pkg::RGB_WHITE;
		else
			colour = pattern;
	end

	always_comb begin
		tft_d.rgb = colour;
		tft_d.de = pos.de;
		tft_d.hsync = pos.hsync;
		tft_d.vsync = pos.vsync;
		tft_d.disp = pos.disp;
	end

	// Colour and controls share one stage so they stay aligned on the panel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tft <= video_pkg::TFT_IDLE;
		else
			tft <= tft_d;
	end

endmodule

//--- hdl/av_out.sv
`timescale 1ns/1ps

module av_out (
	input logic clk,
	input logic rst_n,
	input logic tft_en,
	input logic audio_en,
	input audio_pkg::sample_t audio,
	output video_pkg::tft_out_t tft,
	output logic aout,
	output audio_pkg::sample_t led
);

	video_pkg::tft_pos_t pos;

	// Panel timing
	tft_timing timing0 (
		.clk(clk),
		.rst_n(rst_n),
		.en(tft_en),
		.pos(pos)
	);

	// Audio PWM, the applied duty also drives the LEDs
	apu_pwm pwm0 (
		.clk(clk),
		.rst_n(rst_n),
		.en(audio_en),
		.cmp(audio),
		.q(aout),
		.duty(led)
	);

	// Pixel with level bar, one clock behind the timing
	pixel_compose compose0 (
		.clk(clk),
		.rst_n(rst_n),
		.pos(pos),
		.level(led),
		.tft(tft)
	);

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	// Free-running clock, starts low
	initial begin
		clk = 1'b0;
	end

	always begin
		#(PERIOD / 2);
		clk = ~clk;
	end

endmodule

//--- test/tb_av_out.sv
`timescale 1ns/1ps
`include "av_cfg.svh"

module tb_av_out;

	localparam int PERIOD_NS = 40;
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	// Two and a half frames
	localparam int WATCHDOG_NS = (5 * FRAME_CYCLES * PERIOD_NS) / 2;
	localparam int PWM_PERIOD = 1 << `AUDIO_BITS;
	localparam int H_ACT_START = `H_SYNC + `H_BACK;
	localparam int V_ACT_START = `V_SYNC + `V_BACK;

	// Black pixel with no data, syncs high and the panel off
	localparam video_pkg::tft_out_t TFT_BLANK = {24'h000000, 1'b0, 1'b1, 1'b1, 1'b0};

	logic clk;
	logic rst_n;
	logic tft_en;
	logic audio_en;
	audio_pkg::sample_t audio;
	video_pkg::tft_out_t tft;
	logic aout;
	audio_pkg::sample_t led;

	bit [31:0] rng;
	int errors;
	bit want_tft_en;
	bit audio_on;
	int blank_len;
	int run_len;

	// Reference model state
	int m_h;
	int m_v;
	logic m_disp;
	int m_cnt;
	audio_pkg::sample_t m_duty;
	logic m_q;
	video_pkg::tft_out_t m_tft;
	bit px_de;
	int px_x;
	int px_y;
	audio_pkg::sample_t px_level;
	bit pwm_step;
	int pwm_before;

	// Frame statistics
	bit tally_on;
	int de_cycles;
	int hsync_lows;
	int vsync_lows;
	int de_lines;
	int de_run;
	logic prev_de;
	int bar_white;
	bit bar_stable;
	audio_pkg::sample_t bar_level;
	int bar_lines;
	int period_high;
	audio_pkg::sample_t period_duty;
	int periods_done;
	audio_pkg::sample_t prev_led;

	tb_clock #(.PERIOD(PERIOD_NS)) clock0 (.clk(clk));

	av_out dut (
		.clk(clk),
		.rst_n(rst_n),
		.tft_en(tft_en),
		.audio_en(audio_en),
		.audio(audio),
		.tft(tft),
		.aout(aout),
		.led(led)
	);

	function automatic bit [31:0] lcg_next(input bit [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Colour rules of the panel in priority order
	function automatic video_pkg::rgb_t ref_colour(input bit de, input int x, input int y,
			input int level);
		video_pkg::rgb_t c;
		if (!de)
			c = 24'h000000;
		else if (x == 0)
			c = 24'hff0000;
		else if (x == `H_ACTIVE - 1)
			c = 24'h00ff00;
		else if (y == 0)
			c = 24'h0000ff;
		else if (y == `V_ACTIVE - 1)
			c = 24'hffff00;
		else if (y >= `BAR_TOP && x < level)
			c = 24'hffffff;
		else if ((x & 9'h100) != 0) begin
			c.r = 8'h00;
			c.g = 8'(y);
			c.b = 8'(x);
		end else begin
			c.r = 8'(x);
			c.g = 8'(y);
			c.b = 8'h00;
		end
		return c;
	endfunction

	task automatic raise_error(input string msg);
		errors++;
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_tft(input string name, input video_pkg::tft_out_t got,
			input video_pkg::tft_out_t exp);
		if (got !== exp)
			raise_error($sformatf("ERROR at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_sample(input string name, input audio_pkg::sample_t got,
			input audio_pkg::sample_t exp);
		if (got !== exp)
			raise_error($sformatf("ERROR at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			raise_error($sformatf("ERROR at %0t ns: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			raise_error($sformatf("ERROR at %0t ns: %s count is %0d, expected %0d",
				$time, name, got, exp));
	endtask

	// One clock of the model with the inputs seen at this edge
	task automatic model_update();
		bit h_act;
		bit v_act;
		if (!rst_n) begin
			m_h = 0;
			m_v = 0;
			m_disp = 1'b0;
			m_cnt = 0;
			m_duty = '0;
			m_q = 1'b0;
			m_tft = TFT_BLANK;
			px_de = 1'b0;
			px_x = 0;
			px_y = 0;
			px_level = '0;
			pwm_step = 1'b0;
			pwm_before = 0;
		end else begin
			h_act = tft_en && m_h >= H_ACT_START && m_h < H_ACT_START + `H_ACTIVE;
			v_act = tft_en && m_v >= V_ACT_START && m_v < V_ACT_START + `V_ACTIVE;
			px_de = h_act && v_act;
			px_x = h_act ? m_h - H_ACT_START : 0;
			px_y = v_act ? m_v - V_ACT_START : 0;
			px_level = m_duty;
			m_tft.rgb = ref_colour(px_de, px_x, px_y, int'(m_duty));
			m_tft.de = px_de;
			m_tft.hsync = !(tft_en && m_h < `H_SYNC);
			m_tft.vsync = !(tft_en && m_v < `V_SYNC);
			m_tft.disp = m_disp;

			if (!tft_en) begin
				m_h = 0;
				m_v = 0;
			end else if (m_h == `H_TOTAL - 1) begin
				m_h = 0;
				m_v = (m_v == `V_TOTAL - 1) ? 0 : m_v + 1;
			end else begin
				m_h = m_h + 1;
			end
			m_disp = tft_en;

			pwm_step = audio_en;
			pwm_before = m_cnt;
			if (audio_en) begin
				m_q = m_cnt < int'(m_duty);
				if (m_cnt == PWM_PERIOD - 1)
					m_duty = audio;
				m_cnt = (m_cnt + 1) % PWM_PERIOD;
			end
		end
	endtask

	task automatic tally_frame();
		if (tft.de)
			de_cycles++;
		if (!tft.hsync)
			hsync_lows++;
		if (!tft.vsync)
			vsync_lows++;
		if (tft.de) begin
			de_run++;
		end else if (prev_de) begin
			de_lines++;
			check_count("de run in line", de_run, `H_ACTIVE);
			de_run = 0;
		end
		prev_de = tft.de;
	endtask

	// White pixels per bar line where the level held still
	task automatic tally_bar();
		if (px_de && px_y >= `BAR_TOP && px_y <= `V_ACTIVE - 2) begin
			if (px_x == 1) begin
				bar_white = 0;
				bar_stable = 1'b1;
				bar_level = px_level;
			end
			if (px_x >= 1 && px_level != bar_level)
				bar_stable = 1'b0;
			if (px_x >= 1 && tft.rgb == 24'hffffff)
				bar_white++;
			if (px_x == `H_ACTIVE - 1 && bar_stable) begin
				check_count("white bar pixel", bar_white,
					(bar_level == 0) ? 0 : int'(bar_level) - 1);
				bar_lines++;
			end
		end
	endtask

	task automatic tally_pwm();
		if (pwm_step) begin
			if (pwm_before == 0) begin
				period_high = 0;
				period_duty = m_duty;
			end
			if (aout)
				period_high++;
			if (pwm_before == PWM_PERIOD - 1) begin
				check_count("aout high in period", period_high, int'(period_duty));
				periods_done++;
			end
		end
		if (led !== prev_led && !(pwm_step && pwm_before == PWM_PERIOD - 1))
			raise_error($sformatf("ERROR at %0t ns: led changed outside a PWM period wrap",
				$time));
		prev_led = led;
	endtask

	task automatic drive_inputs();
		rng = lcg_next(rng);
		audio = rng[31 -: `AUDIO_BITS];
		// Roughly one enabled step in four
		audio_en = audio_on && (rng[17:16] == 2'b00);
		tft_en = want_tft_en;
	endtask

	task automatic set_panel(input bit on);
		want_tft_en = on;
		tft_en = on;
	endtask

	task automatic step_cycle();
		@(posedge clk);
		model_update();
		#1;
		check_tft("tft", tft, m_tft);
		check_bit("aout", aout, m_q);
		check_sample("led", led, m_duty);
		if (tally_on)
			tally_frame();
		tally_bar();
		tally_pwm();
		drive_inputs();
	endtask

	initial begin
		#(WATCHDOG_NS);
		raise_error("The test timed out before all checks finished");
	end

	initial begin
		rng = 32'h9731_d0a8;
		errors = 0;
		rst_n = 1'b0;
		tft_en = 1'b0;
		audio_en = 1'b0;
		audio = '0;
		want_tft_en = 1'b0;
		audio_on = 1'b0;
		tally_on = 1'b0;
		de_cycles = 0;
		hsync_lows = 0;
		vsync_lows = 0;
		de_lines = 0;
		de_run = 0;
		prev_de = 1'b0;
		bar_lines = 0;
		periods_done = 0;
		prev_led = '0;

		repeat (8) begin
			step_cycle();
			check_tft("tft in reset", tft, TFT_BLANK);
			check_bit("aout in reset", aout, 1'b0);
			check_sample("led in reset", led, '0);
		end
		rst_n = 1'b1;
		audio_on = 1'b1;

		// Panel still off after reset
		repeat (20) begin
			step_cycle();
			check_tft("tft with panel off", tft, TFT_BLANK);
		end

		set_panel(1'b1);
		tally_on = 1'b1;
		repeat (2 * FRAME_CYCLES)
			step_cycle();
		tally_on = 1'b0;
		check_count("de cycle", de_cycles, 2 * `H_ACTIVE * `V_ACTIVE);
		check_count("hsync low", hsync_lows, 2 * `V_TOTAL * `H_SYNC);
		check_count("vsync low", vsync_lows, 2 * `H_TOTAL * `V_SYNC);
		check_count("line with de", de_lines, 2 * `V_ACTIVE);

		// Stop partway into an active line so the blanking cuts a running frame
		rng = lcg_next(rng);
		run_len = `H_TOTAL * (20 + int'(rng[27:24])) + H_ACT_START + int'(rng[23:16]);
		repeat (run_len)
			step_cycle();

		// Blank for a random stretch
		// The first blanked cycle still shows disp high
		rng = lcg_next(rng);
		blank_len = 20 + int'(rng[31:24]);
		set_panel(1'b0);
		step_cycle();
		repeat (blank_len - 1) begin
			step_cycle();
			check_tft("tft while blanked", tft, TFT_BLANK);
		end

		// Restart lands on line 0 and pixel 0 inside both syncs
		set_panel(1'b1);
		step_cycle();
		check_bit("hsync at restart", tft.hsync, 1'b0);
		check_bit("vsync at restart", tft.vsync, 1'b0);
		repeat (3 * `H_TOTAL)
			step_cycle();

		if (bar_lines == 0)
			raise_error("No level bar line had a steady level, so the bar went unchecked");
		if (periods_done == 0)
			raise_error("No full PWM period was seen, so the duty went unchecked");

		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- tb.f
+incdir+include
hdl/video_pkg.sv
hdl/audio_pkg.sv
hdl/tft_timing.sv
hdl/apu_pwm.sv
hdl/pixel_compose.sv
hdl/av_out.sv
test/tb_clock.sv
test/tb_av_out.sv
